// ==== blink_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module blink_timer #(
	parameter int FLASH_DIV = 12000000
) (
	input  wire logic clk,
	input  wire logic rst_n,
	output logic      flash
);

	localparam int CW = $clog2(FLASH_DIV + 1);

	logic [CW-1:0] div_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			flash   <= 1'b0;
		end else if (div_cnt == CW'(FLASH_DIV - 1)) begin
			div_cnt <= '0;
			flash   <= ~flash; // colon blink phase
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== field_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module field_mux (
	input  wire logic           sw1,
	input  wire logic           time_set,
	input  wire logic           flash,
	input  wire oled_pkg::bcd_t time_hour_high,
	input  wire oled_pkg::bcd_t time_hour_low,
	input  wire oled_pkg::bcd_t time_min_high,
	input  wire oled_pkg::bcd_t time_min_low,
	input  wire oled_pkg::bcd_t time_sec_high,
	input  wire oled_pkg::bcd_t time_sec_low,
	input  wire oled_pkg::bcd_t alarm_hour_high,
	input  wire oled_pkg::bcd_t alarm_hour_low,
	input  wire oled_pkg::bcd_t alarm_min_high,
	input  wire oled_pkg::bcd_t alarm_min_low,
	input  wire oled_pkg::bcd_t temp_high,
	input  wire oled_pkg::bcd_t temp_low,
	input  wire logic [3:0]     field_idx,
	output oled_pkg::char_code_t field_char
);

	oled_pkg::char_code_t colon;

	function automatic oled_pkg::char_code_t digit(input oled_pkg::bcd_t d);
		return 8'h30 + 8'(d);
	endfunction

	assign colon = (time_set && !flash) ? 8'h20 : 8'h3a; // off half of the blink

	always_comb begin
		case (field_idx)
			4'd0:    field_char = colon;
			4'd1:    field_char = sw1 ? 8'h20 : colon; // no seconds in alarm view
			4'd2:    field_char = digit(sw1 ? alarm_hour_high : time_hour_high);
			4'd3:    field_char = digit(sw1 ? alarm_hour_low : time_hour_low);
			4'd4:    field_char = digit(sw1 ? alarm_min_high : time_min_high);
			4'd5:    field_char = digit(sw1 ? alarm_min_low : time_min_low);
			4'd6:    field_char = sw1 ? 8'h20 : digit(time_sec_high);
			4'd7:    field_char = sw1 ? 8'h20 : digit(time_sec_low);
			4'd8:    field_char = digit(temp_high);
			4'd9:    field_char = digit(temp_low);
			default: field_char = 8'h20;
		endcase
	end

endmodule

`default_nettype wire

// ==== font_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module font_rom (
	input  wire oled_pkg::char_code_t glyph_char,
	input  wire logic [2:0]           glyph_col,
	output logic [7:0]                glyph_byte
);

	localparam int GW = 8 * oled_pkg::GLYPH_COLS;

	logic [GW-1:0] glyph; // leftmost column in the top byte

	always_comb begin
		case (glyph_char)
			8'h30:   glyph = 40'h3e_51_49_45_3e; // 0
			8'h31:   glyph = 40'h00_42_7f_40_00;
			8'h32:   glyph = 40'h42_61_51_49_46;
			8'h33:   glyph = 40'h21_41_45_4b_31;
			8'h34:   glyph = 40'h18_14_12_7f_10;
			8'h35:   glyph = 40'h27_45_45_45_39;
			8'h36:   glyph = 40'h3c_4a_49_49_30;
			8'h37:   glyph = 40'h01_71_09_05_03;
			8'h38:   glyph = 40'h36_49_49_49_36;
			8'h39:   glyph = 40'h06_49_49_29_1e; // 9
			8'h3a:   glyph = 40'h00_36_36_00_00; // colon
			8'h45:   glyph = 40'h7f_49_49_49_41; // E
			8'h49:   glyph = 40'h00_41_7f_41_00; // I
			8'h4d:   glyph = 40'h7f_02_0c_02_7f; // M
			8'h54:   glyph = 40'h01_01_7f_01_01; // T
			default: glyph = '0; // space and anything unknown
		endcase
	end

	always_comb begin
		if (int'(glyph_col) < oled_pkg::GLYPH_COLS)
			glyph_byte = glyph[8 * (oled_pkg::GLYPH_COLS - 1 - int'(glyph_col)) +: 8];
		else
			glyph_byte = 8'h00;
	end

endmodule

`default_nettype wire

// ==== oled_cases.txt ====
# sw1 time_set th_h th_l tm_h tm_l ts_h ts_l ah_h ah_l am_h am_l tp_h tp_l (hex)
# then expected ascii of cells: colon1 colon2 hh hl mh ml sh sl temp_h temp_l
0 0 1 2 3 4 5 6 0 7 3 0 2 5 3a 3a 31 32 33 34 35 36 32 35
1 0 1 2 3 4 5 6 0 7 3 0 2 5 20 20 30 37 33 30 20 20 32 35
0 0 2 3 5 9 5 9 0 6 4 5 3 8 3a 3a 32 33 35 39 35 39 33 38
1 0 2 3 5 9 5 9 0 6 4 5 3 8 20 20 30 36 34 35 20 20 33 38
0 0 0 0 0 0 0 0 9 9 9 9 9 9 3a 3a 30 30 30 30 30 30 39 39
1 0 0 0 0 0 0 0 9 9 9 9 9 9 20 20 39 39 39 39 20 20 39 39
0 1 1 8 4 7 2 1 1 1 1 1 4 0 3a 3a 31 38 34 37 32 31 34 30
0 0 0 8 1 6 4 2 2 2 0 0 1 7 3a 3a 30 38 31 36 34 32 31 37
1 0 0 8 1 6 4 2 2 2 0 0 1 7 20 20 32 32 30 30 20 20 31 37
0 1 0 9 5 5 3 3 1 2 3 4 2 6 3a 3a 30 39 35 35 33 33 32 36

// ==== oled_clock_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module oled_clock_display #(
	parameter int FLASH_DIV  = 12000000,
	parameter int RESET_HOLD = 25000,
	parameter int GAP_CYCLES = 5
) (
	input  wire logic           clk,
	input  wire logic           rst_n,
	input  wire logic           sw1,
	input  wire logic           time_set,
	input  wire oled_pkg::bcd_t time_hour_high,
	input  wire oled_pkg::bcd_t time_hour_low,
	input  wire oled_pkg::bcd_t time_min_high,
	input  wire oled_pkg::bcd_t time_min_low,
	input  wire oled_pkg::bcd_t time_sec_high,
	input  wire oled_pkg::bcd_t time_sec_low,
	input  wire oled_pkg::bcd_t alarm_hour_high,
	input  wire oled_pkg::bcd_t alarm_hour_low,
	input  wire oled_pkg::bcd_t alarm_min_high,
	input  wire oled_pkg::bcd_t alarm_min_low,
	input  wire oled_pkg::bcd_t temp_high,
	input  wire oled_pkg::bcd_t temp_low,
	output logic                oled_csn,
	output logic                oled_rst,
	output logic                oled_dcn,
	output logic                oled_clk,
	output logic                oled_dat
);

	logic                 flash;
	logic [3:0]           field_idx;
	oled_pkg::char_code_t field_char;
	oled_pkg::char_code_t glyph_char;
	logic [2:0]           glyph_col;
	logic [7:0]           glyph_byte;
	logic                 tx_start;
	logic [7:0]           tx_byte;
	oled_pkg::dc_t        tx_dc;
	logic                 tx_done;

	blink_timer #(.FLASH_DIV(FLASH_DIV)) u_blink (
		.clk   (clk),
		.rst_n (rst_n),
		.flash (flash)
	);

	field_mux u_field (
		.sw1             (sw1),
		.time_set        (time_set),
		.flash           (flash),
		.time_hour_high  (time_hour_high),
		.time_hour_low   (time_hour_low),
		.time_min_high   (time_min_high),
		.time_min_low    (time_min_low),
		.time_sec_high   (time_sec_high),
		.time_sec_low    (time_sec_low),
		.alarm_hour_high (alarm_hour_high),
		.alarm_hour_low  (alarm_hour_low),
		.alarm_min_high  (alarm_min_high),
		.alarm_min_low   (alarm_min_low),
		.temp_high       (temp_high),
		.temp_low        (temp_low),
		.field_idx       (field_idx),
		.field_char      (field_char)
	);

	font_rom u_font (
		.glyph_char (glyph_char),
		.glyph_col  (glyph_col),
		.glyph_byte (glyph_byte)
	);

	spi_byte_tx #(.GAP_CYCLES(GAP_CYCLES)) u_spi (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_dc    (tx_dc),
		.tx_done  (tx_done),
		.oled_csn (oled_csn),
		.oled_dcn (oled_dcn),
		.oled_clk (oled_clk),
		.oled_dat (oled_dat)
	);

	oled_seq #(.RESET_HOLD(RESET_HOLD)) u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.field_char (field_char),
		.glyph_byte (glyph_byte),
		.tx_done    (tx_done),
		.oled_rst   (oled_rst),
		.field_idx  (field_idx),
		.glyph_char (glyph_char),
		.glyph_col  (glyph_col),
		.tx_start   (tx_start),
		.tx_byte    (tx_byte),
		.tx_dc      (tx_dc)
	);

endmodule

`default_nettype wire

// ==== oled_pkg.sv ====
`default_nettype none

package oled_pkg;

	typedef enum logic [2:0] {
		idle,
		init,
		main,
		scan,
		write_wait
	} seq_state_t;

	typedef enum logic {
		cmd  = 1'b0,
		data = 1'b1
	} dc_t;

	typedef logic [7:0] char_code_t; // ascii
	typedef logic [3:0] bcd_t;

	localparam int INIT_DEPTH  = 25;
	localparam int GLYPH_COLS  = 5;
	localparam int CELL_PAD    = 3; // blank columns ahead of each glyph
	localparam int PANEL_COLS  = 128;
	localparam int PANEL_PAGES = 4;
	localparam int FIELD_COUNT = 10;

	// controller power-up table
	function automatic logic [7:0] init_cmd(input logic [4:0] idx);
		case (idx)
			5'd0:    return 8'hae; // display off
			5'd1:    return 8'h00;
			5'd2:    return 8'h10;
			5'd3:    return 8'h00;
			5'd4:    return 8'hb0;
			5'd5:    return 8'h81; // contrast
			5'd6:    return 8'hff;
			5'd7:    return 8'ha1;
			5'd8:    return 8'ha6;
			5'd9:    return 8'ha8; // mux ratio, 32 rows
			5'd10:   return 8'h1f;
			5'd11:   return 8'hc8;
			5'd12:   return 8'hd3;
			5'd13:   return 8'h00;
			5'd14:   return 8'hd5;
			5'd15:   return 8'h80;
			5'd16:   return 8'hd9;
			5'd17:   return 8'h1f;
			5'd18:   return 8'hda;
			5'd19:   return 8'h00;
			5'd20:   return 8'hdb;
			5'd21:   return 8'h40;
			5'd22:   return 8'h8d; // charge pump
			5'd23:   return 8'h14;
			5'd24:   return 8'haf; // display on
			default: return 8'he3; // nop
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== oled_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module oled_seq #(
	parameter int RESET_HOLD = 25000
) (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire oled_pkg::char_code_t field_char,
	input  wire logic [7:0]           glyph_byte,
	input  wire logic                 tx_done,
	output logic                      oled_rst,
	output logic [3:0]                field_idx,
	output oled_pkg::char_code_t      glyph_char,
	output logic [2:0]                glyph_col,
	output logic                      tx_start,
	output logic [7:0]                tx_byte,
	output oled_pkg::dc_t             tx_dc
);

	localparam int LBL_TIME   = oled_pkg::PANEL_PAGES; // jobs before this clear pages
	localparam int LBL_TEM    = oled_pkg::PANEL_PAGES + 1;
	localparam int FIELD_BASE = oled_pkg::PANEL_PAGES + 2;
	localparam int FIELD_LAST = FIELD_BASE + oled_pkg::FIELD_COUNT - 1;
	localparam int CELL_W     = oled_pkg::CELL_PAD + oled_pkg::GLYPH_COLS;
	localparam int CLEAR_LAST = oled_pkg::PANEL_COLS / CELL_W - 1;
	localparam int DW         = $clog2(RESET_HOLD + 1);
	localparam logic [39:0] TIME_STR = "TIME:";
	localparam logic [31:0] TEM_STR  = "TEM:";

	oled_pkg::seq_state_t state;
	oled_pkg::seq_state_t back_state;
	logic [2:0]           init_step;
	logic [2:0]           scan_step;
	logic [DW-1:0]        delay_cnt;
	logic [4:0]           cmd_idx;
	logic [3:0]           job;
	logic [1:0]           page;
	logic [7:0]           col;
	logic [3:0]           char_pos;
	logic [3:0]           last_pos;
	logic [2:0]           byte_col; // column inside the 8-wide cell
	oled_pkg::char_code_t cur_char;
	oled_pkg::char_code_t next_char;

	assign field_idx  = job - 4'(FIELD_BASE);
	assign glyph_char = cur_char;
	assign glyph_col  = byte_col - 3'(oled_pkg::CELL_PAD);

	always_comb begin
		if (job < 4'(LBL_TIME))
			next_char = 8'h20;
		else if (job == 4'(LBL_TIME))
			next_char = TIME_STR[8 * (4 - int'(char_pos)) +: 8];
		else if (job == 4'(LBL_TEM))
			next_char = TEM_STR[8 * (3 - int'(char_pos)) +: 8];
		else
			next_char = field_char;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= oled_pkg::idle;
			back_state <= oled_pkg::idle;
			init_step  <= '0;
			scan_step  <= '0;
			delay_cnt  <= '0;
			cmd_idx    <= '0;
			job        <= '0;
			page       <= '0;
			col        <= '0;
			char_pos   <= '0;
			last_pos   <= '0;
			byte_col   <= '0;
			cur_char   <= 8'h20;
			oled_rst   <= 1'b1;
			tx_start   <= 1'b0;
			tx_byte    <= '0;
			tx_dc      <= oled_pkg::cmd;
		end else begin
			tx_start <= 1'b0;
			case (state)
				oled_pkg::idle: begin
					init_step <= '0;
					state     <= oled_pkg::init;
				end
				oled_pkg::init: begin
					case (init_step)
						3'd0: begin
							oled_rst  <= 1'b0;
							delay_cnt <= '0;
							init_step <= 3'd1;
						end
						3'd1, 3'd2: begin // hold low, then settle high
							if (delay_cnt == DW'(RESET_HOLD - 1)) begin
								delay_cnt <= '0;
								oled_rst  <= 1'b1;
								init_step <= init_step + 3'd1;
							end else begin
								delay_cnt <= delay_cnt + 1'b1;
							end
						end
						3'd3: begin
							tx_start   <= 1'b1;
							tx_dc      <= oled_pkg::cmd;
							tx_byte    <= oled_pkg::init_cmd(cmd_idx);
							state      <= oled_pkg::write_wait;
							back_state <= oled_pkg::init;
							cmd_idx    <= cmd_idx + 5'd1;
							if (cmd_idx == 5'(oled_pkg::INIT_DEPTH - 1))
								init_step <= 3'd4;
						end
						default: begin
							job   <= '0;
							state <= oled_pkg::main;
						end
					endcase
				end
				oled_pkg::main: begin
					char_pos  <= '0;
					scan_step <= '0;
					state     <= oled_pkg::scan;
					if (job < 4'(LBL_TIME)) begin
						page     <= job[1:0];
						col      <= 8'd0;
						last_pos <= 4'(CLEAR_LAST);
					end else if (job < 4'(FIELD_BASE)) begin
						page     <= (job == 4'(LBL_TEM)) ? 2'd1 : 2'd0;
						col      <= 8'd0;
						last_pos <= (job == 4'(LBL_TEM)) ? 4'd3 : 4'd4;
					end else begin
						page     <= (field_idx >= 4'd8) ? 2'd1 : 2'd0;
						last_pos <= '0;
						case (field_idx)
							4'd0:    col <= 8'd64;
							4'd1:    col <= 8'd88;
							4'd2:    col <= 8'd48;
							4'd3:    col <= 8'd56;
							4'd4:    col <= 8'd72;
							4'd5:    col <= 8'd80;
							4'd6:    col <= 8'd96;
							4'd7:    col <= 8'd104;
							4'd8:    col <= 8'd40;
							default: col <= 8'd48;
						endcase
					end
				end
				oled_pkg::scan: begin
					if (scan_step == 3'd3) begin
						cur_char  <= next_char; // held for the whole cell
						byte_col  <= '0;
						scan_step <= 3'd4;
					end else begin
						tx_start   <= 1'b1;
						tx_dc      <= (scan_step == 3'd4) ? oled_pkg::data : oled_pkg::cmd;
						state      <= oled_pkg::write_wait;
						back_state <= oled_pkg::scan;
						case (scan_step)
							3'd0: begin
								tx_byte   <= 8'hb0 | {6'd0, page};
								scan_step <= 3'd1;
							end
							3'd1: begin
								tx_byte   <= {4'h0, col[3:0]};
								scan_step <= 3'd2;
							end
							3'd2: begin
								tx_byte   <= 8'h10 | {4'h0, col[7:4]};
								scan_step <= 3'd3;
							end
							default: begin
								tx_byte  <= (byte_col < 3'(oled_pkg::CELL_PAD)) ? 8'h00 : glyph_byte;
								byte_col <= byte_col + 3'd1;
								if (byte_col == 3'(CELL_W - 1)) begin
									if (char_pos == last_pos) begin
										back_state <= oled_pkg::main;
										job <= (job == 4'(FIELD_LAST)) ? 4'(FIELD_BASE) : job + 4'd1;
									end else begin
										char_pos  <= char_pos + 4'd1;
										scan_step <= 3'd3;
									end
								end
							end
						endcase
					end
				end
				oled_pkg::write_wait: begin
					if (tx_done)
						state <= back_state;
				end
				default: state <= oled_pkg::idle;
			endcase
		end
	end

	a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |=> !tx_start);

endmodule

`default_nettype wire

// ==== spi_byte_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_byte_tx #(
	parameter int GAP_CYCLES = 5
) (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          tx_start,
	input  wire logic [7:0]    tx_byte,
	input  wire oled_pkg::dc_t tx_dc,
	output logic               tx_done,
	output logic               oled_csn,
	output logic               oled_dcn,
	output logic               oled_clk,
	output logic               oled_dat
);

	localparam int LAST = 17 + GAP_CYCLES;
	localparam int PW   = $clog2(LAST + 1);

	logic [PW-1:0] phase; // 0 means idle
	logic [7:0]    shift;
	logic          busy;

	assign busy = (phase != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase    <= '0;
			tx_done  <= 1'b0;
			oled_csn <= 1'b1;
			oled_dcn <= 1'b0;
			oled_clk <= 1'b1;
			oled_dat <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				if (tx_start) begin
					phase    <= PW'(1);
					oled_csn <= 1'b0;
					oled_dcn <= tx_dc;
				end
			end else begin
				phase <= (phase == PW'(LAST)) ? '0 : phase + 1'b1;
				if (phase <= PW'(16)) begin
					oled_clk <= ~phase[0]; // odd phase low, even phase high
					if (phase[0])
						oled_dat <= shift[7]; // msb first, changes on fall
				end
				if (phase == PW'(17))
					oled_csn <= 1'b1;
				if (phase == PW'(LAST))
					tx_done <= 1'b1; // end of gap
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && tx_start)
			shift <= tx_byte;
		else if (busy && !phase[0] && phase <= PW'(16))
			shift <= {shift[6:0], 1'b0};
	end

	a_csn_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> oled_csn);

	a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !tx_start);

endmodule

`default_nettype wire

// ==== tb.f ====
oled_pkg.sv
blink_timer.sv
field_mux.sv
font_rom.sv
spi_byte_tx.sv
oled_seq.sv
oled_clock_display.sv
tb_oled_clock_display.sv

// ==== tb_oled_clock_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_oled_clock_display;

	localparam int FLASH_DIV  = 2000;
	localparam int RESET_HOLD = 20;
	localparam int CLK_PERIOD = 40;
	localparam int BYTE_CYC   = 30; // frame, gap and handshake, with slack
	localparam int PASS_CYC   = 10 * 11 * BYTE_CYC;
	localparam int MAX_CASES  = 16;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       sw1, time_set;
	logic [3:0] th_h, th_l, tm_h, tm_l, ts_h, ts_l;
	logic [3:0] ah_h, ah_l, am_h, am_l, tp_h, tp_l;
	wire logic  oled_csn, oled_rst, oled_dcn, oled_clk, oled_dat;

	logic [7:0] ram [0:3][0:127]; // panel shadow memory
	logic [7:0] rx_sh;
	int         rx_bits = 0;
	int         init_cnt = 0;
	int         pass_cnt = 0;
	logic [1:0] cur_page = '0;
	int         cur_col = 0;

	logic [7:0] case_tab [0:MAX_CASES-1][0:23];
	int         order [0:MAX_CASES-1];
	int         num_cases = 0;
	bit         cases_ready = 1'b0;

	logic [7:0] init_tab [0:24] = '{8'hae, 8'h00, 8'h10, 8'h00, 8'hb0, 8'h81, 8'hff, 8'ha1,
		8'ha6, 8'ha8, 8'h1f, 8'hc8, 8'hd3, 8'h00, 8'hd5, 8'h80, 8'hd9, 8'h1f, 8'hda, 8'h00,
		8'hdb, 8'h40, 8'h8d, 8'h14, 8'haf};
	int cell_page [0:9] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1};
	int cell_col  [0:9] = '{64, 88, 48, 56, 72, 80, 96, 104, 40, 48};

	oled_clock_display #(.FLASH_DIV(FLASH_DIV), .RESET_HOLD(RESET_HOLD)) dut (
		.clk (clk), .rst_n (rst_n), .sw1 (sw1), .time_set (time_set),
		.time_hour_high (th_h), .time_hour_low (th_l),
		.time_min_high (tm_h), .time_min_low (tm_l),
		.time_sec_high (ts_h), .time_sec_low (ts_l),
		.alarm_hour_high (ah_h), .alarm_hour_low (ah_l),
		.alarm_min_high (am_h), .alarm_min_low (am_l),
		.temp_high (tp_h), .temp_low (tp_l),
		.oled_csn (oled_csn), .oled_rst (oled_rst), .oled_dcn (oled_dcn),
		.oled_clk (oled_clk), .oled_dat (oled_dat)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic fail_run(input string why);
		$display("ERROR: %s", why);
		stop_with_failure();
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// 5 columns, leftmost first, bit 0 at the top row
	function automatic logic [7:0] expected_glyph(input logic [7:0] ch, input int c);
		logic [39:0] g;
		case (ch)
			8'h30: g = {8'h3e, 8'h51, 8'h49, 8'h45, 8'h3e};
			8'h31: g = {8'h00, 8'h42, 8'h7f, 8'h40, 8'h00};
			8'h32: g = {8'h42, 8'h61, 8'h51, 8'h49, 8'h46};
			8'h33: g = {8'h21, 8'h41, 8'h45, 8'h4b, 8'h31};
			8'h34: g = {8'h18, 8'h14, 8'h12, 8'h7f, 8'h10};
			8'h35: g = {8'h27, 8'h45, 8'h45, 8'h45, 8'h39};
			8'h36: g = {8'h3c, 8'h4a, 8'h49, 8'h49, 8'h30};
			8'h37: g = {8'h01, 8'h71, 8'h09, 8'h05, 8'h03};
			8'h38: g = {8'h36, 8'h49, 8'h49, 8'h49, 8'h36};
			8'h39: g = {8'h06, 8'h49, 8'h49, 8'h29, 8'h1e};
			8'h3a: g = {8'h00, 8'h36, 8'h36, 8'h00, 8'h00};
			8'h45: g = {8'h7f, 8'h49, 8'h49, 8'h49, 8'h41};
			8'h49: g = {8'h00, 8'h41, 8'h7f, 8'h41, 8'h00};
			8'h4d: g = {8'h7f, 8'h02, 8'h0c, 8'h02, 8'h7f};
			8'h54: g = {8'h01, 8'h01, 8'h7f, 8'h01, 8'h01};
			default: g = '0;
		endcase
		return g[8 * (4 - c) +: 8];
	endfunction

	function automatic bit cell_is(input int page, input int col, input logic [7:0] ch);
		bit ok;
		ok = 1'b1;
		for (int i = 0; i < 8; i++)
			if (ram[page][col + i] !== ((i < 3) ? 8'h00 : expected_glyph(ch, i - 3)))
				ok = 1'b0;
		return ok;
	endfunction

	task automatic check_cell(input int page, input int col, input logic [7:0] ch);
		logic [7:0] exp;
		for (int i = 0; i < 8; i++) begin
			exp = (i < 3) ? 8'h00 : expected_glyph(ch, i - 3); // 3 pad columns
			check_val($sformatf("ram[%0d][%0d]", page, col + i), ram[page][col + i], exp);
		end
	endtask

	task automatic check_labels();
		string s0;
		string s1;
		s0 = "TIME:";
		s1 = "TEM:";
		for (int i = 0; i < 5; i++)
			check_cell(0, 8 * i, s0[i]);
		for (int i = 0; i < 4; i++)
			check_cell(1, 8 * i, s1[i]);
	endtask

	task automatic wait_passes(input int n);
		int target;
		target = pass_cnt + n;
		wait (pass_cnt >= target);
		@(negedge clk);
	endtask

	task automatic run_case(input int idx);
		bit         seen_on;
		bit         seen_off;
		int         samples;
		time        t0;
		logic [7:0] exp_ch;
		@(negedge clk);
		sw1 = case_tab[idx][0][0];
		time_set = case_tab[idx][1][0];
		{th_h, th_l, tm_h, tm_l} = {case_tab[idx][2][3:0], case_tab[idx][3][3:0],
			case_tab[idx][4][3:0], case_tab[idx][5][3:0]};
		{ts_h, ts_l, ah_h, ah_l} = {case_tab[idx][6][3:0], case_tab[idx][7][3:0],
			case_tab[idx][8][3:0], case_tab[idx][9][3:0]};
		{am_h, am_l, tp_h, tp_l} = {case_tab[idx][10][3:0], case_tab[idx][11][3:0],
			case_tab[idx][12][3:0], case_tab[idx][13][3:0]};
		if (!time_set) begin
			wait_passes(3); // partial pass, then two full ones
			check_labels();
			for (int c = 0; c < 10; c++) begin
				exp_ch = (c == 0) ? 8'h3a : case_tab[idx][14 + c]; // colon 1 in both views
				check_cell(cell_page[c], cell_col[c], exp_ch);
			end
		end else begin
			wait_passes(1);
			seen_on = 1'b0;
			seen_off = 1'b0;
			samples = 0;
			t0 = 0;
			while (!(seen_on && seen_off)) begin
				wait_passes(1);
				if (samples == 0)
					t0 = $time;
				samples++;
				if ($time - t0 > 3 * FLASH_DIV * CLK_PERIOD)
					fail_run("colon at page 0 column 64 did not blink within 3 flash periods");
				for (int c = 2; c < 10; c++)
					check_cell(cell_page[c], cell_col[c], case_tab[idx][14 + c]);
				if (cell_is(0, 64, 8'h3a))
					seen_on = 1'b1;
				else if (cell_is(0, 64, 8'h20))
					seen_off = 1'b1;
				else
					fail_run("colon cell at page 0 column 64 holds neither colon nor space");
			end
		end
	endtask

	// panel model
	always @(posedge oled_clk) begin
		if (rst_n && !oled_csn) begin
			rx_sh = {rx_sh[6:0], oled_dat};
			rx_bits++;
		end
	end

	always @(posedge oled_csn) begin
		if (rst_n) begin
			if (rx_bits != 8)
				fail_run("SPI frame did not carry exactly 8 clock pulses");
			if (!oled_dcn) begin
				if (init_cnt < 25) begin
					check_val($sformatf("init_cmd[%0d]", init_cnt), rx_sh, init_tab[init_cnt]);
					init_cnt++;
				end else begin
					case (rx_sh[7:4])
						4'h0: cur_col = (cur_col & 8'hf0) | rx_sh[3:0];
						4'h1: cur_col = (cur_col & 8'h0f) | (rx_sh[3:0] << 4);
						4'hb: cur_page = rx_sh[1:0];
						default: ;
					endcase
				end
			end else begin
				if (init_cnt < 25)
					fail_run("data byte sent before the init command table finished");
				ram[cur_page][cur_col] = rx_sh;
				if (cur_page == 2'd1 && cur_col == 55)
					pass_cnt++; // last column of the last refreshed cell
				cur_col = (cur_col + 1) % 128;
			end
			rx_bits = 0;
		end
	end

	initial begin
		int limit;
		wait (cases_ready);
		limit = 2 * RESET_HOLD + (25 + 4 * 131 + 78) * BYTE_CYC
			+ num_cases * (4 * PASS_CYC + 3 * FLASH_DIV) + 10000;
		repeat (limit) @(posedge clk);
		fail_run("timeout, the run did not complete all cases in time");
	end

	initial begin
		int         fd;
		int         r;
		int         j;
		int         tmp;
		string      line;
		logic [7:0] f [0:23];
		rst_n = 1'b0;
		sw1 = 1'b0;
		time_set = 1'b0;
		{th_h, th_l, tm_h, tm_l, ts_h, ts_l} = '0;
		{ah_h, ah_l, am_h, am_l, tp_h, tp_l} = '0;
		void'($urandom(32'h15cb));
		fd = $fopen("oled_cases.txt", "r");
		if (fd == 0)
			fail_run("cannot open oled_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (r > 0 && line.len() > 1 && line[0] != "#") begin
				r = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
					f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
					f[22], f[23]);
				if (r != 24)
					fail_run("malformed line in oled_cases.txt");
				if (num_cases >= MAX_CASES)
					fail_run("too many lines in oled_cases.txt");
				for (int k = 0; k < 24; k++)
					case_tab[num_cases][k] = f[k];
				order[num_cases] = num_cases;
				num_cases++;
			end
		end
		$fclose(fd);
		if (num_cases == 0)
			fail_run("oled_cases.txt holds no cases");
		cases_ready = 1'b1;
		for (int i = num_cases - 1; i > 0; i--) begin
			j = $urandom % (i + 1); // shuffle case order
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		repeat (2) @(negedge clk);
		check_val("oled_csn", oled_csn, 1);
		check_val("oled_rst", oled_rst, 1);
		check_val("oled_clk", oled_clk, 1);
		check_val("oled_dat", oled_dat, 0);
		check_val("oled_dcn", oled_dcn, 0);
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		wait (oled_rst === 1'b0); // panel reset pulse
		wait (oled_rst === 1'b1);
		for (int k = 0; k < num_cases; k++)
			run_case(order[k]);
		check_val("init_cnt", init_cnt, 25);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire
